/* src/l1_cache_pkg.sv */
// L1 cache geometry, address field widths and controller state encoding

package l1_cache_pkg;

    // ------------------------------------------------------------------------
    // Geometry: 2 ways, 4 sets, 4 words per line
    // ------------------------------------------------------------------------
    localparam int ADDR_W      = 30;  // Processor word address
    localparam int LINE_ADDR_W = 28;  // Memory line address
    localparam int WORD_W      = 32;
    localparam int LINE_W      = 128; // Word k at bits 32k+31:32k
    localparam int NUM_SETS    = 4;

    // Word address split is tag | set | offset
    localparam int OFFS_W = 2;
    localparam int SET_W  = 2;
    localparam int TAG_W  = 26;       // Word address bits 29:4

    // ------------------------------------------------------------------------
    // Miss handling FSM
    // ------------------------------------------------------------------------
    typedef enum logic [2:0] {
        ST_IDLE       = 3'd0,  // Idle or serving hits
        ST_WB_THEN_RD = 3'd1,  // Victim write-back, read miss pending
        ST_RD         = 3'd2,  // Line fill for a read
        ST_WB_THEN_WR = 3'd3,  // Victim write-back, write miss pending
        ST_RD_FOR_WR  = 3'd4   // Line fill for a write
    } cache_state_e;

endpackage

/* src/cache_way.sv */
// One cache way: valid, dirty, tag and line storage with tag compare and word select

`timescale 1ns/1ps

module cache_way
    import l1_cache_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,

    // Lookup and update controls from the controller
    input  logic [SET_W-1:0]    i_set,
    input  logic [TAG_W-1:0]    i_tag,
    input  logic [OFFS_W-1:0]   i_offs,
    input  logic                i_word_we,
    input  logic [WORD_W-1:0]   i_wdata,
    input  logic                i_fill_we,
    input  logic                i_fill_dirty,
    input  logic [LINE_W-1:0]   i_fill_line,

    // Lookup results for the current set
    output logic                o_hit,
    output logic [WORD_W-1:0]   o_rdata,
    output logic                o_dirty,
    output logic [TAG_W-1:0]    o_tag,
    output logic [LINE_W-1:0]   o_line
);

    logic [NUM_SETS-1:0] valid_q;
    logic [NUM_SETS-1:0] dirty_q;
    logic [TAG_W-1:0]    tag_q  [NUM_SETS];
    logic [LINE_W-1:0]   line_q [NUM_SETS];

    // ------------------------------------------------------------------------
    // Combinational lookup
    // ------------------------------------------------------------------------
    assign o_hit   = valid_q[i_set] && (tag_q[i_set] == i_tag);
    assign o_rdata = line_q[i_set][i_offs*WORD_W +: WORD_W];
    assign o_dirty = dirty_q[i_set];
    assign o_tag   = tag_q[i_set];   // Victim address for write-back
    assign o_line  = line_q[i_set];  // Victim data for write-back

    // ------------------------------------------------------------------------
    // State bits
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (i_fill_we) begin
            valid_q[i_set] <= 1'b1;
            dirty_q[i_set] <= i_fill_dirty;  // Set when filling for a write
        end else if (i_word_we) begin
            dirty_q[i_set] <= 1'b1;
        end
    end

    // Tag and line storage
    always_ff @(posedge clk) begin
        if (i_fill_we) begin
            tag_q[i_set]  <= i_tag;
            line_q[i_set] <= i_fill_line;
        end else if (i_word_we) begin
            // Merge a single word into the stored line
            line_q[i_set][i_offs*WORD_W +: WORD_W] <= i_wdata;
        end
    end

endmodule

/* src/cache_ctrl.sv */
// Cache controller: miss FSM, per-set LRU, memory request registers and read data mux

`timescale 1ns/1ps

module cache_ctrl
    import l1_cache_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,

    // Processor side
    input  logic                    i_proc_read,
    input  logic                    i_proc_write,
    input  logic [ADDR_W-1:0]       i_proc_addr,
    input  logic [WORD_W-1:0]       i_proc_wdata,
    output logic [WORD_W-1:0]       o_proc_rdata,
    output logic                    o_proc_stall,

    // Lookup results from the ways
    input  logic                    i_hit0,
    input  logic                    i_hit1,
    input  logic [WORD_W-1:0]       i_rdata0,
    input  logic [WORD_W-1:0]       i_rdata1,
    input  logic                    i_dirty0,
    input  logic                    i_dirty1,
    input  logic [TAG_W-1:0]        i_tag0,
    input  logic [TAG_W-1:0]        i_tag1,
    input  logic [LINE_W-1:0]       i_line0,
    input  logic [LINE_W-1:0]       i_line1,

    // Controls to the ways
    output logic [SET_W-1:0]        o_set,
    output logic [TAG_W-1:0]        o_tag,
    output logic [OFFS_W-1:0]       o_offs,
    output logic                    o_word_we0,
    output logic                    o_word_we1,
    output logic                    o_fill_we0,
    output logic                    o_fill_we1,
    output logic                    o_fill_dirty,
    output logic [LINE_W-1:0]       o_fill_line,

    // Memory side
    output logic                    o_mem_read,
    output logic                    o_mem_write,
    output logic [LINE_ADDR_W-1:0]  o_mem_addr,
    output logic [LINE_W-1:0]       o_mem_wdata,
    input  logic                    i_mem_ready,
    input  logic [LINE_W-1:0]       i_mem_rdata
);

    cache_state_e        state_q;
    cache_state_e        state_d;
    logic [NUM_SETS-1:0] lru_q;       // Victim way per set
    logic                req;
    logic                hit;
    logic                miss;
    logic                victim;
    logic                victim_dirty;
    logic [TAG_W-1:0]    victim_tag;
    logic [LINE_W-1:0]   victim_line;
    logic                filling;

    // ------------------------------------------------------------------------
    // Address split and lookup
    // ------------------------------------------------------------------------
    assign o_set  = i_proc_addr[OFFS_W +: SET_W];
    assign o_tag  = i_proc_addr[ADDR_W-1 -: TAG_W];
    assign o_offs = i_proc_addr[OFFS_W-1:0];

    assign req  = i_proc_read | i_proc_write;
    assign hit  = i_hit0 | i_hit1;
    assign miss = req & ~hit;

    assign o_proc_stall = miss;
    assign o_proc_rdata = i_hit1 ? i_rdata1 : i_rdata0;

    // Victim selection by LRU
    assign victim       = lru_q[o_set];
    assign victim_dirty = victim ? i_dirty1 : i_dirty0;
    assign victim_tag   = victim ? i_tag1 : i_tag0;
    assign victim_line  = victim ? i_line1 : i_line0;

    // Write hits merge the word at the edge
    assign o_word_we0 = (state_q == ST_IDLE) & i_proc_write & i_hit0;
    assign o_word_we1 = (state_q == ST_IDLE) & i_proc_write & i_hit1;

    // Fill goes into the victim way on the ready cycle
    assign filling      = ((state_q == ST_RD) | (state_q == ST_RD_FOR_WR)) & i_mem_ready;
    assign o_fill_we0   = filling & ~victim;
    assign o_fill_we1   = filling & victim;
    assign o_fill_dirty = (state_q == ST_RD_FOR_WR);
    assign o_fill_line  = i_mem_rdata;

    // ------------------------------------------------------------------------
    // Next state
    // ------------------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (miss) begin
                    if (victim_dirty) begin
                        state_d = i_proc_read ? ST_WB_THEN_RD : ST_WB_THEN_WR;
                    end else begin
                        state_d = i_proc_read ? ST_RD : ST_RD_FOR_WR;
                    end
                end
            end
            ST_WB_THEN_RD: if (i_mem_ready) state_d = ST_RD;
            ST_WB_THEN_WR: if (i_mem_ready) state_d = ST_RD_FOR_WR;
            ST_RD,
            ST_RD_FOR_WR:  if (i_mem_ready) state_d = ST_IDLE;
            default:       state_d = ST_IDLE;
        endcase
    end

    // ------------------------------------------------------------------------
    // State, request strobes and LRU
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q     <= ST_IDLE;
            o_mem_read  <= 1'b0;
            o_mem_write <= 1'b0;
            lru_q       <= '0;
        end else begin
            state_q <= state_d;
            case (state_q)
                ST_IDLE: begin
                    if (miss) begin
                        o_mem_write <= victim_dirty;   // Write-back first if dirty
                        o_mem_read  <= ~victim_dirty;
                    end else if (req) begin
                        lru_q[o_set] <= i_hit0;        // Point at the other way
                    end
                end
                ST_WB_THEN_RD,
                ST_WB_THEN_WR: begin
                    if (i_mem_ready) begin
                        o_mem_write <= 1'b0;
                        o_mem_read  <= 1'b1;
                    end
                end
                default: begin
                    if (i_mem_ready) o_mem_read <= 1'b0;
                end
            endcase
        end
    end

    // Request address and write-back data, held until ready
    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && miss) begin
            o_mem_addr  <= victim_dirty ? {victim_tag, o_set} : {o_tag, o_set};
            o_mem_wdata <= victim_line;
        end else if ((state_q == ST_WB_THEN_RD || state_q == ST_WB_THEN_WR) && i_mem_ready) begin
            o_mem_addr <= {o_tag, o_set};  // Fill address after write-back
        end
    end

endmodule

/* src/l1_cache.sv */
// L1 cache top level: controller and two ways

`timescale 1ns/1ps

module l1_cache
    import l1_cache_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,

    // Processor side
    input  logic                    i_proc_read,
    input  logic                    i_proc_write,
    input  logic [ADDR_W-1:0]       i_proc_addr,
    input  logic [WORD_W-1:0]       i_proc_wdata,
    output logic [WORD_W-1:0]       o_proc_rdata,
    output logic                    o_proc_stall,

    // Memory side
    output logic                    o_mem_read,
    output logic                    o_mem_write,
    output logic [LINE_ADDR_W-1:0]  o_mem_addr,
    output logic [LINE_W-1:0]       o_mem_wdata,
    input  logic                    i_mem_ready,
    input  logic [LINE_W-1:0]       i_mem_rdata
);

    // Shared lookup and fill controls
    logic [SET_W-1:0]  set;
    logic [TAG_W-1:0]  tag;
    logic [OFFS_W-1:0] offs;
    logic              fill_dirty;
    logic [LINE_W-1:0] fill_line;

    // Per-way controls and results
    logic              word_we0, word_we1;
    logic              fill_we0, fill_we1;
    logic              hit0, hit1;
    logic              dirty0, dirty1;
    logic [WORD_W-1:0] rdata0, rdata1;
    logic [TAG_W-1:0]  tag0, tag1;
    logic [LINE_W-1:0] line0, line1;

    cache_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_proc_read  (i_proc_read),
        .i_proc_write (i_proc_write),
        .i_proc_addr  (i_proc_addr),
        .i_proc_wdata (i_proc_wdata),
        .o_proc_rdata (o_proc_rdata),
        .o_proc_stall (o_proc_stall),
        .i_hit0       (hit0),
        .i_hit1       (hit1),
        .i_rdata0     (rdata0),
        .i_rdata1     (rdata1),
        .i_dirty0     (dirty0),
        .i_dirty1     (dirty1),
        .i_tag0       (tag0),
        .i_tag1       (tag1),
        .i_line0      (line0),
        .i_line1      (line1),
        .o_set        (set),
        .o_tag        (tag),
        .o_offs       (offs),
        .o_word_we0   (word_we0),
        .o_word_we1   (word_we1),
        .o_fill_we0   (fill_we0),
        .o_fill_we1   (fill_we1),
        .o_fill_dirty (fill_dirty),
        .o_fill_line  (fill_line),
        .o_mem_read   (o_mem_read),
        .o_mem_write  (o_mem_write),
        .o_mem_addr   (o_mem_addr),
        .o_mem_wdata  (o_mem_wdata),
        .i_mem_ready  (i_mem_ready),
        .i_mem_rdata  (i_mem_rdata)
    );

    // ------------------------------------------------------------------------
    // Ways
    // ------------------------------------------------------------------------
    cache_way u_way0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_set        (set),
        .i_tag        (tag),
        .i_offs       (offs),
        .i_word_we    (word_we0),
        .i_wdata      (i_proc_wdata),
        .i_fill_we    (fill_we0),
        .i_fill_dirty (fill_dirty),
        .i_fill_line  (fill_line),
        .o_hit        (hit0),
        .o_rdata      (rdata0),
        .o_dirty      (dirty0),
        .o_tag        (tag0),
        .o_line       (line0)
    );

    cache_way u_way1 (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_set        (set),
        .i_tag        (tag),
        .i_offs       (offs),
        .i_word_we    (word_we1),
        .i_wdata      (i_proc_wdata),
        .i_fill_we    (fill_we1),
        .i_fill_dirty (fill_dirty),
        .i_fill_line  (fill_line),
        .o_hit        (hit1),
        .o_rdata      (rdata1),
        .o_dirty      (dirty1),
        .o_tag        (tag1),
        .o_line       (line1)
    );

endmodule

/* dv/slow_mem.sv */
// Line-addressed memory model with fixed latency, one-cycle ready and transaction counts

`timescale 1ns/1ps

module slow_mem
    import l1_cache_pkg::*;
#(
    parameter int LATENCY = 5
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   i_mem_read,
    input  logic                   i_mem_write,
    input  logic [LINE_ADDR_W-1:0] i_mem_addr,
    input  logic [LINE_W-1:0]      i_mem_wdata,
    output logic                   o_mem_ready,
    output logic [LINE_W-1:0]      o_mem_rdata,
    output logic [31:0]            o_rd_count,
    output logic [31:0]            o_wr_count,
    output logic [LINE_ADDR_W-1:0] o_last_wr_addr
);

    logic [LINE_W-1:0] lines_q [logic [LINE_ADDR_W-1:0]];  // Only lines written back
    logic              busy_q;
    int                cnt_q;

    // Untouched words hold 2'b10 followed by their word address
    function automatic logic [LINE_W-1:0] initial_line(input logic [LINE_ADDR_W-1:0] line_addr);
        logic [LINE_W-1:0] line;
        for (int k = 0; k < 4; k++) begin
            line[k*WORD_W +: WORD_W] = {2'b10, line_addr, 2'(k)};
        end
        return line;
    endfunction

    always @(posedge clk) begin
        if (!rst_n) begin
            busy_q         <= 1'b0;
            cnt_q          <= 0;
            o_mem_ready    <= 1'b0;
            o_mem_rdata    <= '0;
            o_rd_count     <= '0;
            o_wr_count     <= '0;
            o_last_wr_addr <= '0;
        end else begin
            o_mem_ready <= 1'b0;  // Ready is a single pulse
            if (busy_q) begin
                if (cnt_q == LATENCY - 1) begin
                    busy_q      <= 1'b0;
                    o_mem_ready <= 1'b1;
                    if (i_mem_write) begin
                        lines_q[i_mem_addr] = i_mem_wdata;
                        o_wr_count     <= o_wr_count + 32'd1;
                        o_last_wr_addr <= i_mem_addr;
                    end else begin
                        o_mem_rdata <= lines_q.exists(i_mem_addr) ? lines_q[i_mem_addr]
                                                                  : initial_line(i_mem_addr);
                        o_rd_count  <= o_rd_count + 32'd1;
                    end
                end else begin
                    cnt_q <= cnt_q + 1;
                end
            end else if ((i_mem_read || i_mem_write) && !o_mem_ready) begin
                busy_q <= 1'b1;  // New request seen
                cnt_q  <= 1;
            end
        end
    end

endmodule

/* dv/tb_l1_cache.sv */
// Testbench for the L1 cache: clock, reset, watchdog, LFSR, shadow model and directed tests

`timescale 1ns/1ps

module tb_l1_cache
    import l1_cache_pkg::*;
();

    localparam int          MEM_LATENCY = 5;
    localparam int          CLK_PERIOD  = 8;
    localparam int          MIX_OPS     = 200;
    localparam int          NUM_OPS     = MIX_OPS + 20;
    localparam int          WATCHDOG_NS = (NUM_OPS * (2 * MEM_LATENCY + 6) + 100) * CLK_PERIOD;
    localparam logic [31:0] LFSR_SEED   = 32'he6ea_b63a;
    localparam logic [31:0] LFSR_TAPS   = 32'h8020_0003;

    localparam logic [TAG_W-1:0]         TAG_A      = 26'h010;
    localparam logic [SET_W-1:0]         EVICT_SET  = 2'd2;
    localparam logic [2:0][TAG_W-1:0]    EVICT_TAGS = {26'h023, 26'h022, 26'h021};
    localparam logic [2:0][TAG_W-1:0]    MIX_TAGS   = {26'h033, 26'h032, 26'h031};

    logic                   clk;
    logic                   rst_n;
    logic                   i_proc_read;
    logic                   i_proc_write;
    logic [ADDR_W-1:0]      i_proc_addr;
    logic [WORD_W-1:0]      i_proc_wdata;
    logic [WORD_W-1:0]      o_proc_rdata;
    logic                   o_proc_stall;
    logic                   o_mem_read;
    logic                   o_mem_write;
    logic [LINE_ADDR_W-1:0] o_mem_addr;
    logic [LINE_W-1:0]      o_mem_wdata;
    logic                   i_mem_ready;
    logic [LINE_W-1:0]      i_mem_rdata;
    logic [31:0]            mem_rd_count;
    logic [31:0]            mem_wr_count;
    logic [LINE_ADDR_W-1:0] mem_last_wr_addr;

    logic [31:0]            lfsr_state;
    logic [WORD_W-1:0]      shadow [logic [ADDR_W-1:0]];  // Words written so far
    int                     errors;
    int                     ops_done;

    l1_cache dut (.*);

    slow_mem #(.LATENCY(MEM_LATENCY)) u_mem (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_mem_read     (o_mem_read),
        .i_mem_write    (o_mem_write),
        .i_mem_addr     (o_mem_addr),
        .i_mem_wdata    (o_mem_wdata),
        .o_mem_ready    (i_mem_ready),
        .o_mem_rdata    (i_mem_rdata),
        .o_rd_count     (mem_rd_count),
        .o_wr_count     (mem_wr_count),
        .o_last_wr_addr (mem_last_wr_addr)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns with the run still going", WATCHDOG_NS);
        $display("*** FAILED ***");
        $finish;
    end

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
        end
        return val;
    endfunction

    function automatic logic [ADDR_W-1:0] word_addr(input logic [TAG_W-1:0] tag,
                                                    input logic [SET_W-1:0] set,
                                                    input logic [OFFS_W-1:0] offs);
        return {tag, set, offs};
    endfunction

    function automatic logic [WORD_W-1:0] expected_word(input logic [ADDR_W-1:0] addr);
        if (shadow.exists(addr)) return shadow[addr];
        return {2'b10, addr};  // Memory fill rule
    endfunction

    task automatic note_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        $display("mismatch %s: expected 0x%h, actual 0x%h", name, exp, act);
        errors++;
    endtask

    task automatic fail_check(input string msg);
        $display("error: %s", msg);
        errors++;
    endtask

    // Holds the request until the stall is low at an edge; entered 1 ns after an edge
    task automatic proc_access(input logic is_write, input logic [ADDR_W-1:0] addr,
                               input logic [WORD_W-1:0] wdata,
                               output logic [WORD_W-1:0] rdata, output int stalls);
        logic done;
        done         = 1'b0;
        stalls       = 0;
        rdata        = '0;
        i_proc_read  = ~is_write;
        i_proc_write = is_write;
        i_proc_addr  = addr;
        i_proc_wdata = wdata;
        while (!done) begin
            @(negedge clk);  // Settled since the drive
            if (o_proc_stall) begin
                stalls++;
            end else begin
                rdata = o_proc_rdata;
                done  = 1'b1;
            end
            @(posedge clk);
            #1;
        end
        i_proc_read  = 1'b0;
        i_proc_write = 1'b0;
        ops_done++;
    endtask

    task automatic write_word(input logic [ADDR_W-1:0] addr, input logic [WORD_W-1:0] data,
                              output int stalls);
        logic [WORD_W-1:0] unused_rdata;
        proc_access(1'b1, addr, data, unused_rdata, stalls);
        shadow[addr] = data;
    endtask

    task automatic read_check(input logic [ADDR_W-1:0] addr, output int stalls);
        logic [WORD_W-1:0] exp;
        logic [WORD_W-1:0] rdata;
        exp = expected_word(addr);
        proc_access(1'b0, addr, '0, rdata, stalls);
        if (rdata !== exp) note_mismatch($sformatf("o_proc_rdata @%h", addr), exp, rdata);
    endtask

    // ------------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------------
    task automatic check_idle_after_reset();
        @(negedge clk);
        if (o_mem_read !== 1'b0) note_mismatch("o_mem_read", 32'd0, 32'(o_mem_read));
        if (o_mem_write !== 1'b0) note_mismatch("o_mem_write", 32'd0, 32'(o_mem_write));
        if (o_proc_stall !== 1'b0) note_mismatch("o_proc_stall", 32'd0, 32'(o_proc_stall));
        @(posedge clk);
        #1;
    endtask

    task automatic read_miss_then_hits();
        logic [31:0] rd_before;
        int          stalls;
        rd_before = mem_rd_count;
        read_check(word_addr(TAG_A, 2'd1, 2'd2), stalls);
        if (stalls == 0) fail_check("read miss to a clean set completed without a stall");
        read_check(word_addr(TAG_A, 2'd1, 2'd2), stalls);
        if (stalls != 0) fail_check($sformatf("repeat read stalled for %0d cycles", stalls));
        read_check(word_addr(TAG_A, 2'd1, 2'd0), stalls);
        if (stalls != 0) fail_check($sformatf("same-line read stalled for %0d cycles", stalls));
        if (mem_rd_count !== rd_before + 32'd1) begin
            note_mismatch("mem read count", rd_before + 32'd1, mem_rd_count);
        end
        if (mem_wr_count !== 32'd0) note_mismatch("mem write count", 32'd0, mem_wr_count);
    endtask

    task automatic write_hit_readback();
        logic [ADDR_W-1:0] addr;
        logic [31:0]       rd_before;
        logic [31:0]       wr_before;
        int                stalls;
        addr      = word_addr(TAG_A, 2'd1, 2'd3);
        rd_before = mem_rd_count;
        wr_before = mem_wr_count;
        write_word(addr, rand_bits(32), stalls);
        if (stalls != 0) fail_check("write hit stalled");
        read_check(addr, stalls);
        if (stalls != 0) fail_check("read after write hit stalled");
        if (mem_rd_count !== rd_before) note_mismatch("mem read count", rd_before, mem_rd_count);
        if (mem_wr_count !== wr_before) note_mismatch("mem write count", wr_before, mem_wr_count);
    endtask

    task automatic dirty_victim_eviction();
        logic [LINE_ADDR_W-1:0] victim_line_addr;
        logic [31:0]            wr_before;
        int                     stalls;
        write_word(word_addr(EVICT_TAGS[0], EVICT_SET, 2'd1), rand_bits(32), stalls);
        write_word(word_addr(EVICT_TAGS[1], EVICT_SET, 2'd1), rand_bits(32), stalls);
        // Last hit went to the second line, so the first one is least recently used
        victim_line_addr = {EVICT_TAGS[0], EVICT_SET};
        wr_before        = mem_wr_count;
        write_word(word_addr(EVICT_TAGS[2], EVICT_SET, 2'd1), rand_bits(32), stalls);
        if (mem_wr_count !== wr_before + 32'd1) begin
            note_mismatch("mem write count", wr_before + 32'd1, mem_wr_count);
        end
        if (mem_last_wr_addr !== victim_line_addr) begin
            note_mismatch("o_mem_addr", 32'(victim_line_addr), 32'(mem_last_wr_addr));
        end
        read_check(word_addr(EVICT_TAGS[0], EVICT_SET, 2'd1), stalls);
        if (stalls == 0) fail_check("read of the evicted line did not miss");
    endtask

    task automatic random_read_write_mix();
        logic [31:0]       r;
        logic [ADDR_W-1:0] addr;
        int                tag_idx;
        int                stalls;
        for (int n = 0; n < MIX_OPS; n++) begin
            r       = rand_bits(2);
            tag_idx = int'(r) % 3;
            r       = rand_bits(4);
            addr    = word_addr(MIX_TAGS[tag_idx], r[3:2], r[1:0]);
            r       = rand_bits(1);
            if (r[0]) begin
                write_word(addr, rand_bits(32), stalls);
            end else begin
                read_check(addr, stalls);
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        errors       = 0;
        ops_done     = 0;
        lfsr_state   = LFSR_SEED;
        rst_n        = 1'b0;
        i_proc_read  = 1'b0;
        i_proc_write = 1'b0;
        i_proc_addr  = '0;
        i_proc_wdata = '0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        check_idle_after_reset();
        read_miss_then_hits();
        write_hit_readback();
        dirty_victim_eviction();
        random_read_write_mix();

        $display("ops %0d, mem reads %0d, mem writes %0d, errors %0d",
                 ops_done, mem_rd_count, mem_wr_count, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* l1_cache.f */
src/l1_cache_pkg.sv
src/cache_way.sv
src/cache_ctrl.sv
src/l1_cache.sv
dv/slow_mem.sv
dv/tb_l1_cache.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_l1_cache
FILELIST  ?= l1_cache.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_TEXT ?= *** PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)
